// File: logic/part_buf_params.svh
`ifndef PART_BUF_PARAMS_SVH
`define PART_BUF_PARAMS_SVH

// Block width, one OTP read returns one block
`define PART_BLK_W 64

// Blocks in the partition, the last one holds the digest
`define PART_NUM_BLKS 4

// Byte offset of the partition inside the OTP macro
`define PART_OFFSET 16

// OTP works on halfword addresses
`define OTP_ADDR_W 10
`define OTP_ADDR_SHIFT 1
`define OTP_BYTE_ADDR_W (`OTP_ADDR_W + `OTP_ADDR_SHIFT)

// Block counter width
`define PART_CNT_W 2

`endif

// File: logic/part_buf_pkg.sv
`default_nettype none

package part_buf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Error codes
  ////////////////////////////////////////////////////////////////////////////

  // Same code points as the OTP macro error response
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h6,
    FsmStateError       = 3'h7
  } otp_err_e;

  ////////////////////////////////////////////////////////////////////////////
  // Partition FSM states
  ////////////////////////////////////////////////////////////////////////////

  // Sparse codes, a single bit flip never lands on another legal state
  typedef enum logic [7:0] {
    ResetSt         = 8'b0110_1001,
    InitSt          = 8'b1100_0110,
    InitWaitSt      = 8'b0001_1110,
    IdleSt          = 8'b1011_1000,
    CnstyReadSt     = 8'b0111_0011,
    CnstyReadWaitSt = 8'b1000_1101,
    ErrorSt         = 8'b1110_0101
  } part_state_e;

endpackage : part_buf_pkg

`default_nettype wire

// File: logic/part_buf_if.sv
`default_nettype none

`include "part_buf_params.svh"

// FSM to buffer registers
interface buf_if;
  logic                                 wren;
  logic [`PART_CNT_W-1:0]               addr;
  logic [`PART_BLK_W-1:0]               wdata;
  // Block at addr, read back for the consistency check
  logic [`PART_BLK_W-1:0]               rdata;
  logic                                 par_err;

  modport fsm_mp (output wren, addr, wdata, input rdata, par_err);
  modport buf_mp (input wren, addr, wdata, output rdata, par_err);
endinterface : buf_if

// FSM to redundant block counter
interface cnt_if;
  logic                   cnt_en;
  logic                   cnt_clr;
  logic [`PART_CNT_W-1:0] cnt;
  // Up and down counters disagree
  logic                   cnt_err;

  modport fsm_mp (output cnt_en, cnt_clr, input cnt, cnt_err);
  modport cnt_mp (input cnt_en, cnt_clr, output cnt, cnt_err);
endinterface : cnt_if

`default_nettype wire

// File: logic/part_fsm.sv
`default_nettype none

`include "part_buf_params.svh"

module part_fsm import part_buf_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   init_req_i,
  input  wire logic                   integ_chk_req_i,
  input  wire logic                   cnsty_chk_req_i,
  input  wire logic                   escalate_en_i,
  input  wire logic                   check_byp_en_i,
  input  wire logic                   otp_gnt_i,
  input  wire logic                   otp_rvalid_i,
  input  wire logic [`PART_BLK_W-1:0] otp_rdata_i,
  input  wire otp_err_e               otp_err_i,
  input  wire logic                   locked_i,
  output logic                        integ_chk_ack_o,
  output logic                        cnsty_chk_ack_o,
  output otp_err_e                    error_o,
  output logic                        fsm_err_o,
  output logic                        otp_req_o,
  output logic                        unlock_o,
  output logic                        lock_o,
  buf_if.fsm_mp                       buf_bus,
  cnt_if.fsm_mp                       cnt_bus
);

  localparam int unsigned last_blk_int = `PART_NUM_BLKS - 1;
  localparam logic [`PART_CNT_W-1:0] last_blk = last_blk_int[`PART_CNT_W-1:0];

  part_state_e state_d, state_q;
  otp_err_e    error_d, error_q;
  logic        rsp_ok;

  assign error_o = error_q;

  // Buffer slot follows the block counter, data comes straight from OTP
  assign buf_bus.addr  = cnt_bus.cnt;
  assign buf_bus.wdata = otp_rdata_i;

  // Data usable, a correctable ECC error only gets latched
  assign rsp_ok = (otp_err_i == NoError) || (otp_err_i == MacroEccCorrError);

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    fsm_err_o       = 1'b0;
    otp_req_o       = 1'b0;
    unlock_o        = 1'b0;
    lock_o          = 1'b0;
    integ_chk_ack_o = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    buf_bus.wren    = 1'b0;
    cnt_bus.cnt_en  = 1'b0;
    cnt_bus.cnt_clr = 1'b0;

    case (state_q)
      // Wait for the single init pulse
      ResetSt: begin
        if (init_req_i) begin
          state_d = InitSt;
        end
      end
      // Request held with a stable address until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Store block, then next block or unlock after the last one
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (rsp_ok) begin
            buf_bus.wren = 1'b1;
            if (cnt_bus.cnt == last_blk) begin
              state_d  = IdleSt;
              unlock_o = locked_i;
            end else begin
              state_d        = InitSt;
              cnt_bus.cnt_en = 1'b1;
            end
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      // No hardware digest here, integrity requests are acked at once
      IdleSt: begin
        if (integ_chk_req_i) begin
          integ_chk_ack_o = 1'b1;
        end else if (cnsty_chk_req_i) begin
          state_d         = CnstyReadSt;
          cnt_bus.cnt_clr = 1'b1;
        end
      end
      // Background re-read of every block
      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = CnstyReadWaitSt;
        end
      end
      CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (rsp_ok) begin
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
            // Compare against the buffer unless bypassed
            if (buf_bus.rdata == otp_rdata_i || check_byp_en_i) begin
              if (cnt_bus.cnt == last_blk) begin
                state_d         = IdleSt;
                cnsty_chk_ack_o = 1'b1;
              end else begin
                state_d        = CnstyReadSt;
                cnt_bus.cnt_en = 1'b1;
              end
            end else begin
              state_d         = ErrorSt;
              error_d         = CheckFailError;
              cnsty_chk_ack_o = 1'b1;
            end
          end else begin
            state_d         = ErrorSt;
            error_d         = otp_err_i;
            cnsty_chk_ack_o = 1'b1;
          end
        end
      end
      // Terminal, lock down and ack everything
      ErrorSt: begin
        lock_o = !locked_i;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        integ_chk_ack_o = 1'b1;
        cnsty_chk_ack_o = 1'b1;
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Buffer corruption
    if (buf_bus.par_err) begin
      state_d = ErrorSt;
      if (state_q != ErrorSt) begin
        error_d = CheckFailError;
      end
    end

    // Escalation or counter fault, keeps an already latched code
    if (escalate_en_i || cnt_bus.cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule : part_fsm

`default_nettype wire

// File: logic/part_blk_cnt.sv
`default_nettype none

`include "part_buf_params.svh"

module part_blk_cnt (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  cnt_if.cnt_mp                      cnt_bus,
  output logic [`OTP_ADDR_W-1:0]     otp_addr_o
);

  localparam int unsigned byte_aw      = `OTP_BYTE_ADDR_W;
  localparam int unsigned blk_shift    = $clog2(`PART_BLK_W / 8);
  localparam int unsigned part_off_int = `PART_OFFSET;
  localparam logic [byte_aw-1:0] part_base = part_off_int[byte_aw-1:0];

  logic [`PART_CNT_W-1:0] up_q, down_q;
  logic [byte_aw-1:0]     byte_addr;

  // Down counter mirrors the up counter, sum is always all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q   <= '0;
      down_q <= '1;
    end else if (cnt_bus.cnt_clr) begin
      up_q   <= '0;
      down_q <= '1;
    end else if (cnt_bus.cnt_en) begin
      up_q   <= up_q + 1'b1;
      down_q <= down_q - 1'b1;
    end
  end

  assign cnt_bus.cnt     = up_q;
  assign cnt_bus.cnt_err = (up_q != ~down_q);

  // 8 bytes per block, then byte to halfword
  assign byte_addr  = part_base + byte_aw'({up_q, {blk_shift{1'b0}}});
  assign otp_addr_o = byte_addr[byte_aw-1:`OTP_ADDR_SHIFT];

endmodule : part_blk_cnt

`default_nettype wire

// File: logic/part_buf_regs.sv
`default_nettype none

`include "part_buf_params.svh"

module part_buf_regs (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  buf_if.buf_mp                                      buf_bus,
  output logic [`PART_NUM_BLKS*`PART_BLK_W-1:0]      data_o
);

  logic [`PART_BLK_W-1:0]   blk_q [`PART_NUM_BLKS];
  logic [`PART_NUM_BLKS-1:0] par_q;
  logic [`PART_NUM_BLKS-1:0] par_mis;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Cleared so that parity is consistent before the readout
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PART_NUM_BLKS; i++) begin
        blk_q[i] <= '0;
      end
      par_q <= '0;
    end else if (buf_bus.wren) begin
      blk_q[buf_bus.addr] <= buf_bus.wdata;
      // Even parity over the written block
      par_q[buf_bus.addr] <= ^buf_bus.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parity check and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `PART_NUM_BLKS; i++) begin
      par_mis[i] = (^blk_q[i]) ^ par_q[i];
    end
  end

  assign buf_bus.par_err = |par_mis;

  // Readback for the consistency check
  assign buf_bus.rdata = blk_q[buf_bus.addr];

  // Block 0 in the low bits, digest on top
  always_comb begin
    for (int i = 0; i < `PART_NUM_BLKS; i++) begin
      data_o[i*`PART_BLK_W +: `PART_BLK_W] = blk_q[i];
    end
  end

endmodule : part_buf_regs

`default_nettype wire

// File: logic/part_access_ctrl.sv
`default_nettype none

`include "part_buf_params.svh"

module part_access_ctrl (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    unlock_i,
  input  wire logic                                    lock_i,
  input  wire logic [`PART_NUM_BLKS*`PART_BLK_W-1:0]   data_i,
  input  wire logic                                    rd_lock_i,
  input  wire logic                                    wr_lock_i,
  output logic                                         locked_o,
  output logic                                         init_done_o,
  output logic [`PART_NUM_BLKS*`PART_BLK_W-1:0]        data_o,
  output logic [`PART_BLK_W-1:0]                       digest_o,
  output logic                                         rd_lock_o,
  output logic                                         wr_lock_o
);

  logic locked_q;
  logic digest_set;

  // Partition starts locked, lock wins over unlock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q <= 1'b1;
    end else if (lock_i) begin
      locked_q <= 1'b1;
    end else if (unlock_i) begin
      locked_q <= 1'b0;
    end
  end

  assign locked_o    = locked_q;
  // Unlocking only happens after a good readout
  assign init_done_o = !locked_q;

  // Hardware output gating
  assign data_o = locked_q ? '0 : data_i;

  // Digest sits in the top block, never gated
  assign digest_o   = data_i[`PART_NUM_BLKS*`PART_BLK_W-1 -: `PART_BLK_W];
  assign digest_set = (digest_o != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Access locks
  ////////////////////////////////////////////////////////////////////////////

  assign rd_lock_o = locked_q | rd_lock_i;
  // A programmed digest makes the partition read-only
  assign wr_lock_o = locked_q | wr_lock_i | digest_set;

endmodule : part_access_ctrl

`default_nettype wire

// File: logic/part_buf_top.sv
`default_nettype none

`include "part_buf_params.svh"

module part_buf_top import part_buf_pkg::*; (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  init_req_i,
  input  wire logic                                  integ_chk_req_i,
  input  wire logic                                  cnsty_chk_req_i,
  input  wire logic                                  escalate_en_i,
  input  wire logic                                  check_byp_en_i,
  input  wire logic                                  rd_lock_i,
  input  wire logic                                  wr_lock_i,
  input  wire logic                                  otp_gnt_i,
  input  wire logic                                  otp_rvalid_i,
  input  wire logic [`PART_BLK_W-1:0]                otp_rdata_i,
  input  wire otp_err_e                              otp_err_i,
  output logic                                       init_done_o,
  output logic                                       integ_chk_ack_o,
  output logic                                       cnsty_chk_ack_o,
  output otp_err_e                                   error_o,
  output logic                                       fsm_err_o,
  output logic                                       rd_lock_o,
  output logic                                       wr_lock_o,
  output logic [`PART_BLK_W-1:0]                     digest_o,
  output logic [`PART_NUM_BLKS*`PART_BLK_W-1:0]      data_o,
  output logic                                       otp_req_o,
  output logic [`OTP_ADDR_W-1:0]                     otp_addr_o
);

  buf_if u_buf_if ();
  cnt_if u_cnt_if ();

  logic                                    unlock;
  logic                                    lock;
  logic                                    locked;
  logic [`PART_NUM_BLKS*`PART_BLK_W-1:0]   buf_data;

  part_fsm u_fsm (
    .clk_i, .rst_ni, .init_req_i, .integ_chk_req_i, .cnsty_chk_req_i,
    .escalate_en_i, .check_byp_en_i, .otp_gnt_i, .otp_rvalid_i,
    .otp_rdata_i, .otp_err_i,
    .locked_i        ( locked   ),
    .integ_chk_ack_o, .cnsty_chk_ack_o, .error_o, .fsm_err_o, .otp_req_o,
    .unlock_o        ( unlock   ),
    .lock_o          ( lock     ),
    .buf_bus         ( u_buf_if ),
    .cnt_bus         ( u_cnt_if )
  );

  part_blk_cnt u_blk_cnt (
    .clk_i, .rst_ni,
    .cnt_bus         ( u_cnt_if ),
    .otp_addr_o
  );

  part_buf_regs u_buf_regs (
    .clk_i, .rst_ni,
    .buf_bus         ( u_buf_if ),
    .data_o          ( buf_data )
  );

  part_access_ctrl u_access_ctrl (
    .clk_i, .rst_ni,
    .unlock_i        ( unlock   ),
    .lock_i          ( lock     ),
    .data_i          ( buf_data ),
    .rd_lock_i, .wr_lock_i,
    .locked_o        ( locked   ),
    .init_done_o, .data_o, .digest_o, .rd_lock_o, .wr_lock_o
  );

endmodule : part_buf_top

`default_nettype wire

// File: testbench/part_buf_chk.sv
`default_nettype none

`include "part_buf_params.svh"

module part_buf_chk import part_buf_pkg::*; (
  input wire logic                                  clk_i,
  input wire logic                                  rst_ni,
  input wire logic                                  otp_req_o,
  input wire logic                                  otp_gnt_i,
  input wire logic                                  init_done_o,
  input wire logic                                  escalate_en_i,
  input wire otp_err_e                              error_o,
  input wire logic [`PART_NUM_BLKS*`PART_BLK_W-1:0] data_o,
  input wire part_state_e                           state_i
);

  // Request stays up until the macro grants it
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o && !otp_gnt_i |=> otp_req_o)
    else $error("OTP request dropped before grant");

  // Nothing leaves the partition while the readout is still running
  data_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {ResetSt, InitSt, InitWaitSt} |-> !init_done_o && data_o == '0)
    else $error("Partition data visible before init done");

  esc_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> error_o != NoError)
    else $error("No error code after escalation");

endmodule : part_buf_chk

bind part_buf_top part_buf_chk u_chk (.*, .state_i ( u_fsm.state_q ));

`default_nettype wire

// File: testbench/part_buf_monitor.sv
`default_nettype none

`include "part_buf_params.svh"

module part_buf_monitor import part_buf_pkg::*; (
  input wire logic                                 clk_i,
  input wire logic                                 rst_ni,
  input wire logic                                 init_done_o,
  input wire logic                                 integ_chk_ack_o,
  input wire logic                                 cnsty_chk_ack_o,
  input wire logic                                 fsm_err_o,
  input wire logic                                 rd_lock_o,
  input wire logic                                 wr_lock_o,
  input wire logic                                 otp_req_o,
  input wire logic                                 otp_gnt_i,
  input wire otp_err_e                             error_o,
  input wire logic [`OTP_ADDR_W-1:0]               otp_addr_o,
  input wire logic [`PART_BLK_W-1:0]               digest_o,
  input wire logic [`PART_NUM_BLKS*`PART_BLK_W-1:0] data_o
);

  string name;
  int test_errs, errors, n_pass, n_fail;
  int integ_acks, cnsty_acks, fsm_errs, reads;
  logic [`OTP_ADDR_W-1:0] addrs [$];

  // Event counters and addresses of accepted requests since reset
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      addrs.delete();
    end else begin
      if (integ_chk_ack_o) integ_acks++;
      if (cnsty_chk_ack_o) cnsty_acks++;
      if (fsm_err_o) fsm_errs++;
      if (otp_req_o && otp_gnt_i) begin
        reads++;
        addrs.push_back(otp_addr_o);
      end
    end
  end

  task automatic compare(input string what, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      $display("Error %s: %s expected %0h actual %0h", name, what, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  task automatic start_test(input string test_name);
    name      = test_name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      n_pass++;
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s with %0d mismatches", name, test_errs);
    end
  endtask

  task automatic report();
    $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_error(input logic [2:0] exp);
    compare("error_o", 256'(exp), 256'(error_o));
  endtask

  task automatic check_done(input logic exp);
    compare("init_done_o", 256'(exp), 256'(init_done_o));
  endtask

  task automatic check_data(input logic [`PART_NUM_BLKS*`PART_BLK_W-1:0] exp);
    compare("data_o", 256'(exp), 256'(data_o));
  endtask

  // Digest is never gated by the lock
  task automatic check_digest(input logic [`PART_BLK_W-1:0] exp);
    compare("digest_o", 256'(exp), 256'(digest_o));
  endtask

  task automatic check_locks(input logic exp_rd, input logic exp_wr);
    compare("rd_lock_o", 256'(exp_rd), 256'(rd_lock_o));
    compare("wr_lock_o", 256'(exp_wr), 256'(wr_lock_o));
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    compare(what, 256'(exp), 256'(act));
  endtask

  // Both acks held high in the error state
  task automatic check_acks_high();
    compare("integ_chk_ack_o", 256'(1), 256'(integ_chk_ack_o));
    compare("cnsty_chk_ack_o", 256'(1), 256'(cnsty_chk_ack_o));
  endtask

  // Halfword addresses of blocks 0 to 3 in readout order
  task automatic check_addrs();
    int exp_addr [`PART_NUM_BLKS] = '{8, 12, 16, 20};
    check_count("OTP read count", `PART_NUM_BLKS, addrs.size());
    for (int i = 0; i < `PART_NUM_BLKS && i < addrs.size(); i++) begin
      compare($sformatf("otp_addr_o of block %0d", i),
              256'(exp_addr[i]), 256'(addrs[i]));
    end
  endtask

endmodule : part_buf_monitor

`default_nettype wire

// File: testbench/tb_part_buf.sv
`default_nettype none

`include "part_buf_params.svh"

module tb_part_buf import part_buf_pkg::*; ();

  localparam int unsigned stim_words = 64;
  localparam int unsigned cycles_per_test = 200;

  logic clk_i, rst_ni, init_req_i, integ_chk_req_i, cnsty_chk_req_i;
  logic escalate_en_i, check_byp_en_i, rd_lock_i, wr_lock_i;
  logic otp_gnt_i, otp_rvalid_i;
  logic [`PART_BLK_W-1:0] otp_rdata_i;
  otp_err_e otp_err_i;
  logic init_done_o, integ_chk_ack_o, cnsty_chk_ack_o, fsm_err_o;
  logic rd_lock_o, wr_lock_o, otp_req_o;
  otp_err_e error_o;
  logic [`PART_BLK_W-1:0] digest_o, exp_digest;
  logic [`PART_NUM_BLKS*`PART_BLK_W-1:0] data_o, exp_data;
  logic [`OTP_ADDR_W-1:0] otp_addr_o;

  logic [63:0] stim [stim_words];
  logic [`PART_BLK_W-1:0] otp_mem [`PART_NUM_BLKS];
  integer seed;
  int gnt_wait, rsp_idx, inj_blk, cycles, cycle_limit;
  logic digest_nz;
  logic [2:0] inj_code;

  part_buf_top UUT (.*);
  part_buf_monitor u_mon (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Run limit scales with the number of tests
  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run stopped, cycle limit of %0d reached", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // OTP macro model
  ////////////////////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles and answer in the cycle after the grant
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      otp_gnt_i    = 1'b0;
      otp_rvalid_i = 1'b0;
    end else begin
      otp_rvalid_i = 1'b0;
      otp_err_i    = NoError;
      if (otp_gnt_i) begin
        otp_gnt_i    = 1'b0;
        otp_rvalid_i = 1'b1;
        otp_rdata_i  = otp_mem[rsp_idx];
        if (rsp_idx == inj_blk) otp_err_i = otp_err_e'(inj_code);
        gnt_wait = $unsigned($random(seed)) % 4;
      end else if (otp_req_o) begin
        if (gnt_wait == 0) begin
          otp_gnt_i = 1'b1;
          // Halfword address back to block index
          rsp_idx = (int'(otp_addr_o) * (1 << `OTP_ADDR_SHIFT) - `PART_OFFSET) / 8;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic pulse_input(ref logic sig);
    sig = 1'b1;
    @(negedge clk_i);
    sig = 1'b0;
  endtask

  task automatic run_init(input logic [63:0] arg, input logic [2:0] exp_err, input logic ok);
    apply_reset();
    // Locked and blank before the readout
    u_mon.check_data('0);
    u_mon.check_digest('0);
    u_mon.check_locks(1'b1, 1'b1);
    // Low argument byte of ff means a clean readout
    if (arg[7:0] == 8'hff) begin
      inj_blk = 255;
    end else begin
      inj_blk = int'(arg[15:8]);
    end
    inj_code = arg[2:0];
    pulse_input(init_req_i);
    while (!(init_done_o || (error_o != NoError && error_o != MacroEccCorrError))) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    inj_blk = 255;
    u_mon.check_error(exp_err);
    u_mon.check_done(ok);
    u_mon.check_data(ok ? exp_data : '0);
    // Digest block only lands in the buffer after a good readout
    u_mon.check_digest(ok ? exp_digest : '0);
    if (ok) u_mon.check_addrs();
  endtask

  task automatic run_integ();
    int reads0;
    int acks0;
    u_mon.check_locks(1'b0, digest_nz);
    rd_lock_i = 1'b1;
    @(negedge clk_i);
    u_mon.check_locks(1'b1, 1'b1);
    rd_lock_i = 1'b0;
    reads0 = u_mon.reads;
    acks0  = u_mon.integ_acks;
    pulse_input(integ_chk_req_i);
    @(negedge clk_i);
    u_mon.check_count("integrity acks", acks0 + 1, u_mon.integ_acks);
    u_mon.check_count("OTP reads", reads0, u_mon.reads);
  endtask

  task automatic run_cnsty(input logic [63:0] arg, input logic [2:0] exp_err, input logic ok);
    int acks0;
    int blk;
    // Low argument byte of ff means unchanged memory and no bypass
    if (arg[7:0] == 8'hff) begin
      blk = 255;
      check_byp_en_i = 1'b0;
    end else begin
      blk = int'(arg[15:8]);
      check_byp_en_i = arg[0];
    end
    if (blk < `PART_NUM_BLKS) otp_mem[blk][0] = ~otp_mem[blk][0];
    acks0 = u_mon.cnsty_acks;
    pulse_input(cnsty_chk_req_i);
    while (u_mon.cnsty_acks == acks0) @(negedge clk_i);
    // Lock register follows the error state one cycle later
    repeat (2) @(negedge clk_i);
    u_mon.check_error(exp_err);
    u_mon.check_data(ok ? exp_data : '0);
    u_mon.check_digest(exp_digest);
    u_mon.check_locks(!ok, !ok || digest_nz);
    if (blk < `PART_NUM_BLKS) otp_mem[blk][0] = ~otp_mem[blk][0];
    check_byp_en_i = 1'b0;
  endtask

  task automatic run_escalate(input logic [2:0] exp_err);
    int errs0;
    errs0 = u_mon.fsm_errs;
    pulse_input(escalate_en_i);
    repeat (2) @(negedge clk_i);
    u_mon.check_error(exp_err);
    u_mon.check_count("fsm_err pulses", errs0 + 1, u_mon.fsm_errs);
    u_mon.check_data('0);
    u_mon.check_digest(exp_digest);
    u_mon.check_locks(1'b1, 1'b1);
    integ_chk_req_i = 1'b1;
    cnsty_chk_req_i = 1'b1;
    @(negedge clk_i);
    u_mon.check_acks_high();
    integ_chk_req_i = 1'b0;
    cnsty_chk_req_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    logic [63:0] cmd, arg, exp, ok;
    rst_ni = 1'b0;
    init_req_i = 1'b0;
    integ_chk_req_i = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i = 1'b0;
    check_byp_en_i = 1'b0;
    rd_lock_i = 1'b0;
    wr_lock_i = 1'b0;
    otp_gnt_i = 1'b0;
    otp_rvalid_i = 1'b0;
    otp_rdata_i = '0;
    otp_err_i = NoError;
    seed = 32'h1cd1_fe28;
    gnt_wait = 0;
    inj_blk = 255;
    inj_code = 3'h0;
    cycles = 0;
    cycle_limit = 0;
    $readmemh("testbench/part_buf_stim.txt", stim);
    for (int i = 0; i < `PART_NUM_BLKS; i++) begin
      otp_mem[i] = stim[i];
      exp_data[i*`PART_BLK_W +: `PART_BLK_W] = stim[i];
    end
    exp_digest = stim[`PART_NUM_BLKS-1];
    digest_nz = (exp_digest != '0);
    n = int'(stim[4][7:0]);
    cycle_limit = cycles_per_test * n;
    for (int t = 0; t < n; t++) begin
      cmd = stim[5+4*t];
      arg = stim[6+4*t];
      exp = stim[7+4*t];
      ok  = stim[8+4*t];
      case (cmd[7:0])
        8'h01: begin
          u_mon.start_test($sformatf("%0d_init", t));
          run_init(arg, exp[2:0], ok[0]);
        end
        8'h02: begin
          u_mon.start_test($sformatf("%0d_integ_locks", t));
          run_integ();
        end
        8'h03: begin
          u_mon.start_test($sformatf("%0d_cnsty", t));
          run_cnsty(arg, exp[2:0], ok[0]);
        end
        default: begin
          u_mon.start_test($sformatf("%0d_escalate", t));
          run_escalate(exp[2:0]);
        end
      endcase
      u_mon.end_test();
    end
    u_mon.report();
    if (u_mon.errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_part_buf

`default_nettype wire

// File: testbench/part_buf_stim.txt
// OTP blocks 0 to 3 (block 3 is the digest), then the number of tests,
// then per test: command, argument, expected error code, expected unlocked
0123456789abcdef
0f1e2d3c4b5a6978
a5a5a5a55a5a5a5a
00000000c0de0bad
9
// Commands: 1 init (arg block and injected code), 2 integrity and locks,
// 3 consistency (arg block to flip and bypass bit), 4 escalation
1 00ff 0 1
2 0 0 1
3 00ff 0 1
3 0201 0 1
3 0200 6 0
1 0102 2 1
1 0203 3 0
1 00ff 0 1
4 0 7 0

// File: project.f
+incdir+logic
logic/part_buf_pkg.sv
logic/part_buf_if.sv
logic/part_fsm.sv
logic/part_blk_cnt.sv
logic/part_buf_regs.sv
logic/part_access_ctrl.sv
logic/part_buf_top.sv
testbench/part_buf_chk.sv
testbench/part_buf_monitor.sv
testbench/tb_part_buf.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_part_buf
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
